/* list.f */
+incdir+verif
src/cpu_pkg.sv
src/sram.sv
src/register_file.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_writeback.sv
src/cpu.sv
verif/cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps
PASS_MSG  := *** TEST PASSED ***

SRCS := $(filter-out +%,$(shell cat list.f))
HDRS := $(wildcard verif/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): list.f $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f list.f

# pass or fail comes from the printed result, not the exit status
run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* verif/cpu_tests.svh */
// CPU directed tests
// each test loads its own program, runs it and checks data memory
// against values worked out from the instruction set rules

task automatic test_external_access();
   word_t       imem_data[3];
   word_t       dmem_data[3];
   int unsigned imem_addr[3] = '{3, 100, 511};
   int unsigned dmem_addr[3] = '{0, 77, 1023};
   word_t       got;
   reset_dut();
   for (int k = 0; k < 3; k++) begin
      random_word(imem_data[k]);
      random_word(dmem_data[k]);
      write_mem(1'b1, imem_addr[k], imem_data[k]);
      write_mem(1'b0, dmem_addr[k], dmem_data[k]);
   end
   for (int k = 0; k < 3; k++) begin
      read_mem(1'b1, imem_addr[k], got);
      check_word($sformatf("imem_rdata[%0d]", imem_addr[k]), got, imem_data[k]);
      check_dmem(dmem_addr[k], dmem_data[k]);
   end
endtask

// every instruction uses the result of the one before it
task automatic test_forwarding();
   word_t e[1:8];
   fill_dmem(16, 8);
   prog.push_back(enc_i(OP_ADDI, 1, 0, 'h1234));
   prog.push_back(enc_i(OP_ADDI, 2, 1, -256));
   prog.push_back(enc_r(FN_ADD, 3, 2, 1));
   prog.push_back(enc_r(FN_SUB, 4, 1, 3));
   prog.push_back(enc_r(FN_AND, 5, 4, 3));
   prog.push_back(enc_r(FN_OR, 6, 5, 2));
   prog.push_back(enc_r(FN_SLT, 7, 4, 6));
   prog.push_back(enc_i(OP_ADDI, 8, 7, 5));
   prog.push_back(enc_i(OP_SW, 8, 0, 92));
   for (int r = 1; r < 8; r++) begin
      prog.push_back(enc_i(OP_SW, r, 0, 60 + 4 * r));
   end
   run_program(RUN_CYCLES);
   e[1] = 32'h0000_1234;
   e[2] = e[1] - 32'd256;
   e[3] = e[2] + e[1];
   e[4] = e[1] - e[3];
   e[5] = e[4] & e[3];
   e[6] = e[5] | e[2];
   e[7] = ($signed(e[4]) < $signed(e[6])) ? 32'd1 : 32'd0;
   e[8] = e[7] + 32'd5;
   for (int r = 1; r <= 8; r++) begin
      check_dmem(15 + r, e[r]);
   end
endtask

task automatic test_load_use();
   word_t value;
   random_word(value);
   write_mem(1'b0, 40, value);
   fill_dmem(41, 2);
   prog.push_back(enc_i(OP_ADDI, 3, 0, 'h0777));
   prog.push_back(enc_i(OP_LW, 1, 0, 160));
   prog.push_back(enc_r(FN_ADD, 2, 1, 3));
   prog.push_back(enc_i(OP_SW, 2, 0, 164));
   // loaded value on the rt side this time
   prog.push_back(enc_i(OP_LW, 4, 0, 160));
   prog.push_back(enc_r(FN_ADD, 5, 3, 4));
   prog.push_back(enc_i(OP_SW, 5, 0, 168));
   run_program(RUN_CYCLES);
   check_dmem(41, value + 32'h0000_0777);
   check_dmem(42, value + 32'h0000_0777);
endtask

// skipped stores write a marker, so any leak shows in the region
task automatic test_control_flow();
   word_t exp[8];
   fill_dmem(48, 8);
   prog.push_back(enc_i(OP_ADDI, 1, 0, 7));
   prog.push_back(enc_i(OP_ADDI, 2, 0, 7));
   prog.push_back(enc_i(OP_ADDI, 9, 0, 'h00aa));
   prog.push_back(enc_i(OP_BEQ, 2, 1, 2));
   prog.push_back(enc_i(OP_SW, 9, 0, 192));
   prog.push_back(enc_i(OP_SW, 9, 0, 196));
   prog.push_back(enc_i(OP_ADDI, 3, 0, 3));
   prog.push_back(enc_i(OP_BEQ, 3, 1, 1));
   prog.push_back(enc_i(OP_SW, 3, 0, 200));
   prog.push_back(enc_j(12));
   prog.push_back(enc_i(OP_SW, 9, 0, 204));
   prog.push_back(enc_i(OP_SW, 9, 0, 208));
   prog.push_back(enc_i(OP_SW, 1, 0, 212));
   run_program(RUN_CYCLES);
   for (int k = 0; k < 8; k++) begin
      exp[k] = fill_word(48 + k);
   end
   exp[2] = 32'd3;
   exp[5] = 32'd7;
   for (int k = 0; k < 8; k++) begin
      check_dmem(48 + k, exp[k]);
   end
endtask

task automatic test_random_data();
   word_t v[8];
   word_t sum;
   for (int k = 0; k < 8; k++) begin
      random_word(v[k]);
      write_mem(1'b0, 64 + k, v[k]);
   end
   fill_dmem(72, 5);
   for (int k = 0; k < 8; k++) begin
      prog.push_back(enc_i(OP_LW, k + 1, 0, 256 + 4 * k));
   end
   prog.push_back(enc_r(FN_ADD, 9, 1, 2));
   for (int r = 3; r <= 8; r++) begin
      prog.push_back(enc_r(FN_ADD, 9, 9, r));
   end
   prog.push_back(enc_r(FN_SUB, 10, 1, 2));
   prog.push_back(enc_r(FN_AND, 11, 3, 4));
   prog.push_back(enc_r(FN_SLT, 12, 5, 6));
   prog.push_back(enc_r(FN_SLT, 13, 8, 7));
   for (int r = 9; r <= 13; r++) begin
      prog.push_back(enc_i(OP_SW, r, 0, 288 + 4 * (r - 9)));
   end
   run_program(RUN_CYCLES);
   sum = '0;
   for (int k = 0; k < 8; k++) begin
      sum = sum + v[k];
   end
   check_dmem(72, sum);
   check_dmem(73, v[0] - v[1]);
   check_dmem(74, v[2] & v[3]);
   check_dmem(75, ($signed(v[4]) < $signed(v[5])) ? 32'd1 : 32'd0);
   check_dmem(76, ($signed(v[7]) < $signed(v[6])) ? 32'd1 : 32'd0);
endtask

/* verif/cpu_tb.sv */
// CPU testbench
// clock, reset and the cpu instance, external memory access, random words
// and instruction encoding; the directed tests come from the included file
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;
   import cpu_pkg::*;

   localparam int RESET_CYCLES = 8;
   localparam int RUN_CYCLES   = 64;
   localparam int NUM_TESTS    = 5;
   // totals over all tests, rounded up
   localparam int PROG_WORDS   = 80;
   localparam int MEM_WRITES   = 48;
   localparam int MEM_READS    = 40;
   localparam int TIMEOUT_CYCLES = NUM_TESTS * (RESET_CYCLES + RUN_CYCLES + 4) +
                                   2 * (PROG_WORDS + MEM_WRITES) + 3 * MEM_READS + 200;

   logic     clk = 1'b0;
   logic     arst_n = 1'b0;
   logic     enable = 1'b0;
   mem_ext_t imem_ext = '0;
   mem_ext_t dmem_ext = '0;
   word_t    imem_rdata;
   word_t    dmem_rdata;
   word_t    lfsr_state = 32'h2910_bd19;
   int       cycle_count = 0;
   word_t    prog[$];

   cpu #(
      .IMEM_ADDR_W(9),
      .DMEM_ADDR_W(10)
   ) dut0 (
      .clk       (clk),
      .arst_n    (arst_n),
      .enable    (enable),
      .imem_ext  (imem_ext),
      .dmem_ext  (dmem_ext),
      .imem_rdata(imem_rdata),
      .dmem_rdata(dmem_rdata)
   );

   always #2 clk = ~clk;

   task automatic stop_with_error(string msg);
      $display("%s", msg);
      $display("*** TEST FAILED ***");
      $fatal(1);
   endtask

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         stop_with_error($sformatf("timeout: the run did not end within %0d cycles",
                                   TIMEOUT_CYCLES));
      end
   end

   task automatic check_word(string name, word_t got, word_t exp);
      assert (got === exp)
      else stop_with_error($sformatf("FAIL %s got %h expected %h", name, got, exp));
   endtask

   // Galois form, one step per output bit
   function automatic word_t lfsr_next(word_t s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic random_word(output word_t w);
      w = '0;
      for (int b = 0; b < 32; b++) begin
         w = {w[30:0], lfsr_state[0]};
         lfsr_state = lfsr_next(lfsr_state);
      end
   endtask

   function automatic word_t enc_r(logic [5:0] funct, int rd, int rs, int rt);
      return {OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
   endfunction

   function automatic word_t enc_i(logic [5:0] op, int rt, int rs, int imm);
      return {op, rs[4:0], rt[4:0], imm[15:0]};
   endfunction

   // index is the word address of the target
   function automatic word_t enc_j(int index);
      return {OP_J, index[25:0]};
   endfunction

   function automatic word_t fill_word(int unsigned index);
      return index ^ 32'h6b2c_0000;
   endfunction

   task automatic write_mem(bit to_imem, int unsigned index, word_t data);
      @(posedge clk);
      if (to_imem) begin
         imem_ext.addr  <= index;
         imem_ext.wdata <= data;
         imem_ext.wen   <= 1'b1;
      end else begin
         dmem_ext.addr  <= index;
         dmem_ext.wdata <= data;
         dmem_ext.wen   <= 1'b1;
      end
      @(posedge clk);
      imem_ext.wen <= 1'b0;
      dmem_ext.wen <= 1'b0;
   endtask

   // data shows one edge after the address, sampled half a cycle later
   task automatic read_mem(bit from_imem, int unsigned index, output word_t data);
      @(posedge clk);
      if (from_imem) begin
         imem_ext.addr <= index;
      end else begin
         dmem_ext.addr <= index;
      end
      @(posedge clk);
      @(negedge clk);
      data = from_imem ? imem_rdata : dmem_rdata;
   endtask

   task automatic check_dmem(int unsigned index, word_t exp);
      word_t got;
      read_mem(1'b0, index, got);
      check_word($sformatf("dmem_rdata[%0d]", index), got, exp);
   endtask

   task automatic fill_dmem(int unsigned first, int unsigned count);
      for (int unsigned a = first; a < first + count; a++) begin
         write_mem(1'b0, a, fill_word(a));
      end
   endtask

   task automatic reset_dut();
      @(posedge clk);
      enable <= 1'b0;
      arst_n <= 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;
   endtask

   // the jump to itself keeps the pipeline idle once the program is done
   task automatic run_program(int cycles);
      prog.push_back(enc_j(prog.size()));
      reset_dut();
      for (int i = 0; i < prog.size(); i++) begin
         write_mem(1'b1, i, prog[i]);
      end
      @(posedge clk);
      enable <= 1'b1;
      repeat (cycles) @(posedge clk);
      enable <= 1'b0;
      prog.delete();
   endtask

   `include "cpu_tests.svh"

   initial begin
      test_external_access();
      test_forwarding();
      test_load_use();
      test_control_flow();
      test_random_data();
      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* src/cpu.sv */
// CPU top level
// five-stage pipeline for a MIPS subset, not-taken prediction with
// branch and jump resolved in execute; both memories expose an external
// port for loading and read-back while enable is low
`timescale 1ns/1ps
`default_nettype none

module cpu #(
   parameter int IMEM_ADDR_W = 9,
   parameter int DMEM_ADDR_W = 10
) (
   input  wire                      clk,
   input  wire                      arst_n,
   input  wire                      enable,
   input  wire cpu_pkg::mem_ext_t   imem_ext,
   input  wire cpu_pkg::mem_ext_t   dmem_ext,
   output cpu_pkg::word_t           imem_rdata,
   output cpu_pkg::word_t           dmem_rdata
);
   import cpu_pkg::*;

   if_id_t    if_id;
   id_ex_t    id_ex;
   ex_mem_t   ex_mem;
   wb_t       wb;
   redirect_t redirect;
   logic      stall;

   fetch_stage #(
      .IMEM_ADDR_W(IMEM_ADDR_W)
   ) fetch0 (
      .clk       (clk),
      .arst_n    (arst_n),
      .enable    (enable),
      .stall     (stall),
      .redirect  (redirect),
      .imem_ext  (imem_ext),
      .imem_rdata(imem_rdata),
      .if_id     (if_id)
   );

   decode_stage decode0 (
      .clk     (clk),
      .arst_n  (arst_n),
      .enable  (enable),
      .if_id   (if_id),
      .redirect(redirect),
      .wb      (wb),
      .stall   (stall),
      .id_ex   (id_ex)
   );

   execute_stage execute0 (
      .clk     (clk),
      .arst_n  (arst_n),
      .enable  (enable),
      .id_ex   (id_ex),
      .ex_mem_q(ex_mem),
      .wb      (wb),
      .redirect(redirect)
   );

   memory_writeback #(
      .DMEM_ADDR_W(DMEM_ADDR_W)
   ) mem_wb0 (
      .clk       (clk),
      .arst_n    (arst_n),
      .enable    (enable),
      .ex_mem    (ex_mem),
      .dmem_ext  (dmem_ext),
      .dmem_rdata(dmem_rdata),
      .wb        (wb)
   );

endmodule

`default_nettype wire

/* src/memory_writeback.sv */
// Memory and write-back
// data memory addressed by the ALU result, the MEM/WB register and the
// write-back select between load data and ALU result
`timescale 1ns/1ps
`default_nettype none

module memory_writeback #(
   parameter int DMEM_ADDR_W = 10
) (
   input  wire                      clk,
   input  wire                      arst_n,
   input  wire                      enable,
   input  wire cpu_pkg::ex_mem_t    ex_mem,
   input  wire cpu_pkg::mem_ext_t   dmem_ext,
   output cpu_pkg::word_t           dmem_rdata,
   output cpu_pkg::wb_t             wb
);
   import cpu_pkg::*;

   word_t     load_data;
   word_t     alu_out_q;
   reg_addr_t dest_q;
   logic      reg_write_q;
   logic      mem_to_reg_q;

   // load data lands together with the MEM/WB register
   sram #(
      .ADDR_W(DMEM_ADDR_W)
   ) dmem (
      .clk      (clk),
      .addr     (ex_mem.alu_out),
      .wdata    (ex_mem.store_data),
      .wen      (ex_mem.mem_write & enable),
      .rdata    (load_data),
      .ext      (dmem_ext),
      .ext_rdata(dmem_rdata)
   );

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         reg_write_q  <= 1'b0;
         mem_to_reg_q <= 1'b0;
      end else if (enable) begin
         reg_write_q  <= ex_mem.reg_write;
         mem_to_reg_q <= ex_mem.mem_to_reg;
      end
   end

   always_ff @(posedge clk) begin
      if (enable) begin
         alu_out_q <= ex_mem.alu_out;
         dest_q    <= ex_mem.dest;
      end
   end

   always_comb begin
      wb.we    = reg_write_q;
      wb.waddr = dest_q;
      wb.wdata = mem_to_reg_q ? load_data : alu_out_q;
   end

endmodule

`default_nettype wire

/* src/execute_stage.sv */
// Execute stage
// operand forwarding, ALU, beq/j resolution and the EX/MEM register;
// a taken branch or any jump redirects fetch
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
   input  wire                      clk,
   input  wire                      arst_n,
   input  wire                      enable,
   input  wire cpu_pkg::id_ex_t     id_ex,
   output cpu_pkg::ex_mem_t         ex_mem_q,
   input  wire cpu_pkg::wb_t        wb,
   output cpu_pkg::redirect_t       redirect
);
   import cpu_pkg::*;

   word_t   op_a;
   word_t   rt_fwd;
   word_t   op_b;
   word_t   alu_out;
   word_t   branch_target;
   ex_mem_t ex_mem_d;

   // EX/MEM first (a load there has no data yet), then MEM/WB
   function automatic word_t forward(reg_addr_t src, word_t reg_val);
      if (ex_mem_q.reg_write && !ex_mem_q.mem_read &&
          (ex_mem_q.dest != '0) && (ex_mem_q.dest == src)) begin
         return ex_mem_q.alu_out;
      end
      if (wb.we && (wb.waddr != '0) && (wb.waddr == src)) begin
         return wb.wdata;
      end
      return reg_val;
   endfunction

   always_comb op_a   = forward(id_ex.rs, id_ex.rs_data);
   always_comb rt_fwd = forward(id_ex.rt, id_ex.rt_data);

   assign op_b = id_ex.ctrl.alu_src ? id_ex.imm : rt_fwd;

   always_comb begin
      case (id_ex.ctrl.alu_fn)
         ALU_ADD: alu_out = op_a + op_b;
         ALU_SUB: alu_out = op_a - op_b;
         ALU_AND: alu_out = op_a & op_b;
         ALU_OR:  alu_out = op_a | op_b;
         ALU_SLT: alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
         default: alu_out = '0;
      endcase
   end

   assign branch_target = id_ex.pc_plus4 + {id_ex.imm[29:0], 2'b00};

   always_comb begin
      redirect.taken  = id_ex.ctrl.jump | (id_ex.ctrl.branch & (op_a == rt_fwd));
      redirect.target = id_ex.ctrl.jump ? id_ex.jump_target : branch_target;
   end

   always_comb begin
      ex_mem_d.reg_write  = id_ex.ctrl.reg_write;
      ex_mem_d.mem_read   = id_ex.ctrl.mem_read;
      ex_mem_d.mem_write  = id_ex.ctrl.mem_write;
      ex_mem_d.mem_to_reg = id_ex.ctrl.mem_to_reg;
      ex_mem_d.alu_out    = alu_out;
      ex_mem_d.store_data = rt_fwd;
      ex_mem_d.dest       = id_ex.dest;
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ex_mem_q <= '0;
      end else if (enable) begin
         ex_mem_q <= ex_mem_d;
      end
   end

endmodule

`default_nettype wire

/* src/decode_stage.sv */
// Decode stage
// control decode, register read, immediate and jump-target forming,
// load-use hazard detection and the ID/EX register
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
   input  wire                      clk,
   input  wire                      arst_n,
   input  wire                      enable,
   input  wire cpu_pkg::if_id_t     if_id,
   input  wire cpu_pkg::redirect_t  redirect,
   input  wire cpu_pkg::wb_t        wb,
   output logic                     stall,
   output cpu_pkg::id_ex_t          id_ex
);
   import cpu_pkg::*;

   instr_u    ins;
   ctrl_t     ctrl;
   word_t     rs_data;
   word_t     rt_data;
   word_t     imm;
   reg_addr_t dest;
   id_ex_t    id_ex_d;

   assign ins = if_id.instr;

   // unknown opcode or funct leaves everything at zero
   always_comb begin
      ctrl = '0;
      if (if_id.valid) begin
         case (ins.r.opcode)
            OP_RTYPE: begin
               ctrl.reg_write = 1'b1;
               ctrl.reg_dst   = 1'b1;
               case (ins.r.funct)
                  FN_ADD:  ctrl.alu_fn = ALU_ADD;
                  FN_SUB:  ctrl.alu_fn = ALU_SUB;
                  FN_AND:  ctrl.alu_fn = ALU_AND;
                  FN_OR:   ctrl.alu_fn = ALU_OR;
                  FN_SLT:  ctrl.alu_fn = ALU_SLT;
                  default: ctrl = '0;
               endcase
            end
            OP_ADDI: begin
               ctrl.reg_write = 1'b1;
               ctrl.alu_src   = 1'b1;
            end
            OP_LW: begin
               ctrl.reg_write  = 1'b1;
               ctrl.mem_read   = 1'b1;
               ctrl.mem_to_reg = 1'b1;
               ctrl.alu_src    = 1'b1;
            end
            OP_SW: begin
               ctrl.mem_write = 1'b1;
               ctrl.alu_src   = 1'b1;
            end
            OP_BEQ: begin
               ctrl.branch = 1'b1;
            end
            OP_J: begin
               ctrl.jump = 1'b1;
            end
            default: ctrl = '0;
         endcase
      end
   end

   assign imm  = {{16{ins.i.imm[15]}}, ins.i.imm};
   assign dest = ctrl.reg_dst ? ins.r.rd : ins.r.rt;

   // load in EX whose result is needed right here
   assign stall = if_id.valid & id_ex.ctrl.mem_read &
                  ((id_ex.dest == ins.r.rs) | (id_ex.dest == ins.r.rt));

   register_file rf (
      .clk    (clk),
      .arst_n (arst_n),
      .raddr_1(ins.r.rs),
      .raddr_2(ins.r.rt),
      .wb     (wb),
      .rdata_1(rs_data),
      .rdata_2(rt_data)
   );

   always_comb begin
      id_ex_d.ctrl        = (stall | redirect.taken) ? '0 : ctrl;
      id_ex_d.pc_plus4    = if_id.pc_plus4;
      id_ex_d.rs_data     = rs_data;
      id_ex_d.rt_data     = rt_data;
      id_ex_d.imm         = imm;
      id_ex_d.rs          = ins.r.rs;
      id_ex_d.rt          = ins.r.rt;
      id_ex_d.dest        = dest;
      id_ex_d.jump_target = {if_id.pc_plus4[31:28], ins.j.target, 2'b00};
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         id_ex <= '0;
      end else if (enable) begin
         id_ex <= id_ex_d;
      end
   end

endmodule

`default_nettype wire

/* src/fetch_stage.sv */
// Fetch stage
// program counter and instruction memory; the sram output register is the
// IF/ID instruction, so a stall re-presents the address held in IF/ID
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
   parameter int IMEM_ADDR_W = 9
) (
   input  wire                      clk,
   input  wire                      arst_n,
   input  wire                      enable,
   input  wire                      stall,
   input  wire cpu_pkg::redirect_t  redirect,
   input  wire cpu_pkg::mem_ext_t   imem_ext,
   output cpu_pkg::word_t           imem_rdata,
   output cpu_pkg::if_id_t          if_id
);
   import cpu_pkg::*;

   word_t pc;
   word_t pc_next;
   word_t fetch_addr;
   word_t instr_word;
   word_t pc_plus4_q;
   logic  valid_q;
   logic  fetch_en;

   assign fetch_en = enable & ~stall;

   // redirect has priority over the stall hold
   always_comb begin
      if (redirect.taken) begin
         pc_next = redirect.target;
      end else if (stall) begin
         pc_next = pc;
      end else begin
         pc_next = pc + 32'd4;
      end
   end

   // keep the sram pointed at the IF/ID instruction while not fetching
   assign fetch_addr = fetch_en ? pc : pc_plus4_q - 32'd4;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc         <= '0;
         pc_plus4_q <= '0;
         valid_q    <= 1'b0;
      end else if (enable) begin
         pc <= pc_next;
         if (redirect.taken) begin
            valid_q <= 1'b0;
         end else if (!stall) begin
            valid_q    <= 1'b1;
            pc_plus4_q <= pc + 32'd4;
         end
      end
   end

   sram #(
      .ADDR_W(IMEM_ADDR_W)
   ) imem (
      .clk      (clk),
      .addr     (fetch_addr),
      .wdata    ('0),
      .wen      (1'b0),
      .rdata    (instr_word),
      .ext      (imem_ext),
      .ext_rdata(imem_rdata)
   );

   always_comb begin
      if_id.valid    = valid_q;
      if_id.pc_plus4 = pc_plus4_q;
      if_id.instr    = instr_word;
   end

endmodule

`default_nettype wire

/* src/register_file.sv */
// Register file
// 32 x 32 registers, two asynchronous read ports; a read of the register
// being written returns the new value, r0 always reads zero
`timescale 1ns/1ps
`default_nettype none

module register_file (
   input  wire                      clk,
   input  wire                      arst_n,
   input  wire cpu_pkg::reg_addr_t  raddr_1,
   input  wire cpu_pkg::reg_addr_t  raddr_2,
   input  wire cpu_pkg::wb_t        wb,
   output cpu_pkg::word_t           rdata_1,
   output cpu_pkg::word_t           rdata_2
);
   import cpu_pkg::*;

   word_t regs [32];

   function automatic word_t read_port(reg_addr_t raddr);
      if (raddr == '0) begin
         return '0;
      end
      if (wb.we && (wb.waddr == raddr)) begin
         return wb.wdata;
      end
      return regs[raddr];
   endfunction

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wb.we && (wb.waddr != '0)) begin
         regs[wb.waddr] <= wb.wdata;
      end
   end

   always_comb rdata_1 = read_port(raddr_1);
   always_comb rdata_2 = read_port(raddr_2);

endmodule

`default_nettype wire

/* src/sram.sv */
// Word SRAM
// two synchronous-read ports on one array: an internal port addressed by
// byte address and an external port addressed by word index
`timescale 1ns/1ps
`default_nettype none

module sram #(
   parameter int ADDR_W = 9
) (
   input  wire                      clk,
   input  wire cpu_pkg::word_t      addr,
   input  wire cpu_pkg::word_t      wdata,
   input  wire                      wen,
   output cpu_pkg::word_t           rdata,
   input  wire cpu_pkg::mem_ext_t   ext,
   output cpu_pkg::word_t           ext_rdata
);
   import cpu_pkg::*;

   word_t mem [2**ADDR_W];

   always_ff @(posedge clk) begin
      if (wen) begin
         mem[addr[ADDR_W+1:2]] <= wdata;
      end
      // external write comes last so it wins on the same word
      if (ext.wen) begin
         mem[ext.addr[ADDR_W-1:0]] <= ext.wdata;
      end
      rdata     <= mem[addr[ADDR_W+1:2]];
      ext_rdata <= mem[ext.addr[ADDR_W-1:0]];
   end

endmodule

`default_nettype wire

/* src/cpu_pkg.sv */
// CPU package
// shared widths, opcodes, the instruction formats and the pipeline-register
// types for the five-stage MIPS-subset core
`default_nettype none

package cpu_pkg;

   localparam int XLEN = 32;

   typedef logic [XLEN-1:0] word_t;
   typedef logic [4:0]      reg_addr_t;

   localparam logic [5:0] OP_RTYPE = 6'h00;
   localparam logic [5:0] OP_J     = 6'h02;
   localparam logic [5:0] OP_BEQ   = 6'h04;
   localparam logic [5:0] OP_ADDI  = 6'h08;
   localparam logic [5:0] OP_LW    = 6'h23;
   localparam logic [5:0] OP_SW    = 6'h2b;

   localparam logic [5:0] FN_ADD = 6'h20;
   localparam logic [5:0] FN_SUB = 6'h22;
   localparam logic [5:0] FN_AND = 6'h24;
   localparam logic [5:0] FN_OR  = 6'h25;
   localparam logic [5:0] FN_SLT = 6'h2a;

   typedef struct packed {
      logic [5:0] opcode;
      reg_addr_t  rs;
      reg_addr_t  rt;
      reg_addr_t  rd;
      logic [4:0] shamt;
      logic [5:0] funct;
   } r_fmt_t;

   typedef struct packed {
      logic [5:0]  opcode;
      reg_addr_t   rs;
      reg_addr_t   rt;
      logic [15:0] imm;
   } i_fmt_t;

   typedef struct packed {
      logic [5:0]  opcode;
      logic [25:0] target;
   } j_fmt_t;

   // one instruction word, three views
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      j_fmt_t j;
   } instr_u;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT
   } alu_fn_e;

   typedef struct packed {
      logic    reg_write;
      logic    mem_read;
      logic    mem_write;
      logic    mem_to_reg;
      logic    alu_src;
      logic    reg_dst;
      logic    branch;
      logic    jump;
      alu_fn_e alu_fn;
   } ctrl_t;

   // addr is a word index, not a byte address
   typedef struct packed {
      word_t addr;
      logic  wen;
      word_t wdata;
   } mem_ext_t;

   typedef struct packed {
      logic   valid;
      word_t  pc_plus4;
      instr_u instr;
   } if_id_t;

   typedef struct packed {
      ctrl_t     ctrl;
      word_t     pc_plus4;
      word_t     rs_data;
      word_t     rt_data;
      word_t     imm;
      reg_addr_t rs;
      reg_addr_t rt;
      reg_addr_t dest;
      word_t     jump_target;
   } id_ex_t;

   typedef struct packed {
      logic      reg_write;
      logic      mem_read;
      logic      mem_write;
      logic      mem_to_reg;
      word_t     alu_out;
      word_t     store_data;
      reg_addr_t dest;
   } ex_mem_t;

   typedef struct packed {
      logic      we;
      reg_addr_t waddr;
      word_t     wdata;
   } wb_t;

   typedef struct packed {
      logic  taken;
      word_t target;
   } redirect_t;

endpackage

`default_nettype wire
